// File: verilog/jtag_pkg.sv
`default_nettype none

package jtag_pkg;

	localparam int IR_WIDTH = 4;
	localparam int DR_WIDTH = 32;
	localparam int CFG_WIDTH = 16;
	localparam int EST_WIDTH = 16;
	localparam int ERR_WIDTH = 8;

	typedef logic [IR_WIDTH-1:0] jtag_instr_t;
	typedef logic [DR_WIDTH-1:0] jtag_dr_t;
	typedef logic [CFG_WIDTH-1:0] cfg_word_t;
	typedef logic signed [EST_WIDTH-1:0] est_t;
	typedef logic signed [ERR_WIDTH-1:0] phase_err_t;

	// Instruction codes with bypass for any other value
	localparam jtag_instr_t IR_IDCODE = 4'd1;
	localparam jtag_instr_t IR_CFG_ACORE = 4'd2;
	localparam jtag_instr_t IR_CFG_CDR = 4'd3;
	localparam jtag_instr_t IR_STATUS_CDR = 4'd4;
	localparam jtag_instr_t IR_CFG_DCORE = 4'd5;
	localparam jtag_instr_t IR_BYPASS = 4'd15;

	typedef struct packed {
		logic en_v2t;
		logic en_slice;
		logic en_pm;
		logic en_biasgen;
		logic [3:0] ctl_biasgen;
		logic [3:0] ctl_dcdl_late;
		logic [3:0] ctl_dcdl_early;
	} acore_cfg_t;

	typedef struct packed {
		logic [3:0] Kp;
		logic [3:0] Ki;
		logic en_ext_pi_ctl;
		logic en_freq_est;
		logic [5:0] pi_ctl_ext;
	} cdr_cfg_t;

	typedef struct packed {
		logic int_rstb;
		logic cdr_rstb;
		logic sram_rstb;
		logic en_outbuff;
		logic [3:0] sel_outbuff;
		logic [3:0] Ndiv_outbuff;
		logic [3:0] spare;
	} dcore_cfg_t;

	localparam acore_cfg_t ACORE_RST = '0;
	localparam cdr_cfg_t CDR_RST = '{Kp: 4'd2, default: '0};
	localparam dcore_cfg_t DCORE_RST = '0;

	// IEEE 1149.1 TAP states
	typedef enum logic [3:0] {
		TEST_LOGIC_RESET,
		RUN_TEST_IDLE,
		SELECT_DR_SCAN,
		CAPTURE_DR,
		SHIFT_DR,
		EXIT1_DR,
		PAUSE_DR,
		EXIT2_DR,
		UPDATE_DR,
		SELECT_IR_SCAN,
		CAPTURE_IR,
		SHIFT_IR,
		EXIT1_IR,
		PAUSE_IR,
		EXIT2_IR,
		UPDATE_IR
	} tap_state_t;

endpackage

`default_nettype wire

// File: verilog/jtag_tap_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module jtag_tap_ctrl (
	input  logic clk,
	input  logic reset_i,
	input  logic tck_i,
	input  logic tms_i,
	input  logic tdi_i,
	input  logic trst_n_i,
	output logic tdi_s_o,
	output logic tck_fall_o,
	output logic tap_reset_o,
	output logic capture_dr_o,
	output logic shift_dr_o,
	output logic update_dr_o,
	output logic capture_ir_o,
	output logic shift_ir_o,
	output logic update_ir_o
);
	import jtag_pkg::*;

	logic [1:0] tck_sync;
	logic [1:0] tms_sync;
	logic [1:0] tdi_sync;
	logic [1:0] trst_n_sync;
	logic tck_q;
	logic tck_rise;
	tap_state_t state;
	tap_state_t state_next;

	// Oversample the JTAG pins in the clk domain
	always_ff @(posedge clk) begin
		if (reset_i) begin
			tck_sync <= '0;
			tms_sync <= '1;
			tdi_sync <= '0;
			trst_n_sync <= '1;
			tck_q <= 1'b0;
		end else begin
			tck_sync <= {tck_sync[0], tck_i};
			tms_sync <= {tms_sync[0], tms_i};
			tdi_sync <= {tdi_sync[0], tdi_i};
			trst_n_sync <= {trst_n_sync[0], trst_n_i};
			tck_q <= tck_sync[1];
		end
	end

	assign tck_rise = tck_sync[1] & ~tck_q;
	assign tck_fall_o = ~tck_sync[1] & tck_q;
	assign tdi_s_o = tdi_sync[1];

	always_comb begin
		state_next = state;
		case (state)
			TEST_LOGIC_RESET: state_next = tms_sync[1] ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
			RUN_TEST_IDLE:    state_next = tms_sync[1] ? SELECT_DR_SCAN : RUN_TEST_IDLE;
			SELECT_DR_SCAN:   state_next = tms_sync[1] ? SELECT_IR_SCAN : CAPTURE_DR;
			CAPTURE_DR:       state_next = tms_sync[1] ? EXIT1_DR : SHIFT_DR;
			SHIFT_DR:         state_next = tms_sync[1] ? EXIT1_DR : SHIFT_DR;
			EXIT1_DR:         state_next = tms_sync[1] ? UPDATE_DR : PAUSE_DR;
			PAUSE_DR:         state_next = tms_sync[1] ? EXIT2_DR : PAUSE_DR;
			EXIT2_DR:         state_next = tms_sync[1] ? UPDATE_DR : SHIFT_DR;
			UPDATE_DR:        state_next = tms_sync[1] ? SELECT_DR_SCAN : RUN_TEST_IDLE;
			SELECT_IR_SCAN:   state_next = tms_sync[1] ? TEST_LOGIC_RESET : CAPTURE_IR;
			CAPTURE_IR:       state_next = tms_sync[1] ? EXIT1_IR : SHIFT_IR;
			SHIFT_IR:         state_next = tms_sync[1] ? EXIT1_IR : SHIFT_IR;
			EXIT1_IR:         state_next = tms_sync[1] ? UPDATE_IR : PAUSE_IR;
			PAUSE_IR:         state_next = tms_sync[1] ? EXIT2_IR : PAUSE_IR;
			EXIT2_IR:         state_next = tms_sync[1] ? UPDATE_IR : SHIFT_IR;
			UPDATE_IR:        state_next = tms_sync[1] ? SELECT_DR_SCAN : RUN_TEST_IDLE;
			default:          state_next = TEST_LOGIC_RESET;
		endcase
	end

	// TRST_N overrides TMS
	always_ff @(posedge clk) begin
		if (reset_i || !trst_n_sync[1]) begin
			state <= TEST_LOGIC_RESET;
		end else if (tck_rise) begin
			state <= state_next;
		end
	end

	assign tap_reset_o = (state == TEST_LOGIC_RESET);

	// Capture and shift act on the rising edge leaving the state
	assign capture_dr_o = tck_rise && (state == CAPTURE_DR);
	assign shift_dr_o = tck_rise && (state == SHIFT_DR);
	assign capture_ir_o = tck_rise && (state == CAPTURE_IR);
	assign shift_ir_o = tck_rise && (state == SHIFT_IR);

	// Update on the falling edge inside the update state
	assign update_dr_o = tck_fall_o && (state == UPDATE_DR);
	assign update_ir_o = tck_fall_o && (state == UPDATE_IR);

endmodule

`default_nettype wire

// File: verilog/jtag_reg_bank.sv
`timescale 1ns/10ps
`default_nettype none

module jtag_reg_bank #(
	parameter jtag_pkg::jtag_dr_t ID_CODE = '0
) (
	input  logic clk,
	input  logic reset_i,
	input  logic tdi_s_i,
	input  logic tck_fall_i,
	input  logic tap_reset_i,
	input  logic capture_dr_i,
	input  logic shift_dr_i,
	input  logic update_dr_i,
	input  logic capture_ir_i,
	input  logic shift_ir_i,
	input  logic update_ir_i,
	input  jtag_pkg::est_t phase_est_i,
	input  jtag_pkg::est_t freq_est_i,
	output logic tdo_o,
	output jtag_pkg::acore_cfg_t acore_cfg_o,
	output jtag_pkg::cdr_cfg_t cdr_cfg_o,
	output jtag_pkg::dcore_cfg_t dcore_cfg_o
);
	import jtag_pkg::*;

	jtag_instr_t ir;
	jtag_instr_t ir_shift;
	jtag_dr_t dr_shift;
	jtag_dr_t dr_capture;
	jtag_dr_t dr_shifted;
	cfg_word_t upd_word;
	logic ir_path;

	// Value loaded into the data shifter at capture
	always_comb begin
		case (ir)
			IR_IDCODE:     dr_capture = ID_CODE;
			IR_CFG_ACORE:  dr_capture = {{(DR_WIDTH-CFG_WIDTH){1'b0}}, acore_cfg_o};
			IR_CFG_CDR:    dr_capture = {{(DR_WIDTH-CFG_WIDTH){1'b0}}, cdr_cfg_o};
			IR_CFG_DCORE:  dr_capture = {{(DR_WIDTH-CFG_WIDTH){1'b0}}, dcore_cfg_o};
			IR_STATUS_CDR: dr_capture = {phase_est_i, freq_est_i};
			default:       dr_capture = '0;
		endcase
	end

	// TDI enters at the top of the selected register
	always_comb begin
		case (ir)
			IR_IDCODE, IR_STATUS_CDR: begin
				dr_shifted = {tdi_s_i, dr_shift[DR_WIDTH-1:1]};
			end
			IR_CFG_ACORE, IR_CFG_CDR, IR_CFG_DCORE: begin
				dr_shifted = {{(DR_WIDTH-CFG_WIDTH){1'b0}}, tdi_s_i, dr_shift[CFG_WIDTH-1:1]};
			end
			default: begin
				dr_shifted = {{(DR_WIDTH-1){1'b0}}, tdi_s_i};
			end
		endcase
	end

	assign upd_word = dr_shift[CFG_WIDTH-1:0];

	always_ff @(posedge clk) begin
		if (capture_ir_i) begin
			// IEEE capture pattern
			ir_shift <= 4'b0001;
		end else if (shift_ir_i) begin
			ir_shift <= {tdi_s_i, ir_shift[IR_WIDTH-1:1]};
		end
		if (capture_dr_i) begin
			dr_shift <= dr_capture;
		end else if (shift_dr_i) begin
			dr_shift <= dr_shifted;
		end
	end

	// Instruction register and which shifter feeds TDO
	always_ff @(posedge clk) begin
		if (reset_i || tap_reset_i) begin
			ir <= IR_IDCODE;
			ir_path <= 1'b0;
		end else begin
			if (capture_ir_i) begin
				ir_path <= 1'b1;
			end else if (capture_dr_i) begin
				ir_path <= 1'b0;
			end
			if (update_ir_i) begin
				ir <= ir_shift;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			tdo_o <= 1'b0;
		end else if (tck_fall_i) begin
			tdo_o <= ir_path ? ir_shift[0] : dr_shift[0];
		end
	end

	// Configuration registers survive a TAP reset
	always_ff @(posedge clk) begin
		if (reset_i) begin
			acore_cfg_o <= ACORE_RST;
			cdr_cfg_o <= CDR_RST;
			dcore_cfg_o <= DCORE_RST;
		end else if (update_dr_i) begin
			case (ir)
				IR_CFG_ACORE: acore_cfg_o <= acore_cfg_t'(upd_word);
				IR_CFG_CDR:   cdr_cfg_o <= cdr_cfg_t'(upd_word);
				IR_CFG_DCORE: dcore_cfg_o <= dcore_cfg_t'(upd_word);
				default:      ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/cdr_loop_filter.sv
`timescale 1ns/10ps
`default_nettype none

module cdr_loop_filter (
	input  logic clk,
	input  logic reset_i,
	input  logic sample_i,
	input  jtag_pkg::phase_err_t phase_err_i,
	input  jtag_pkg::cdr_cfg_t cfg_i,
	input  logic rstb_i,
	output jtag_pkg::est_t phase_est_o,
	output jtag_pkg::est_t freq_est_o
);
	import jtag_pkg::*;

	est_t err_ext;
	est_t freq_next;
	est_t phase_next;

	always_comb begin
		err_ext = {{(EST_WIDTH-ERR_WIDTH){phase_err_i[ERR_WIDTH-1]}}, phase_err_i};
		freq_next = freq_est_o;
		if (cfg_i.en_freq_est) begin
			freq_next = freq_est_o + (err_ext << cfg_i.Ki);
		end
		// Proportional path plus the updated integrator
		phase_next = phase_est_o + (err_ext << cfg_i.Kp) + freq_next;
	end

	always_ff @(posedge clk) begin
		if (reset_i || !rstb_i) begin
			phase_est_o <= '0;
			freq_est_o <= '0;
		end else begin
			if (sample_i) begin
				freq_est_o <= freq_next;
				phase_est_o <= phase_next;
			end
			// External PI control overrides the phase estimate
			if (cfg_i.en_ext_pi_ctl) begin
				phase_est_o <= {{(EST_WIDTH-6){1'b0}}, cfg_i.pi_ctl_ext};
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/jtag_debug_top.sv
`timescale 1ns/10ps
`default_nettype none

module jtag_debug_top #(
	parameter jtag_pkg::jtag_dr_t ID_CODE = 32'h1A5C0F01
) (
	input  logic clk,
	input  logic reset_i,
	input  logic tck_i,
	input  logic tms_i,
	input  logic tdi_i,
	input  logic trst_n_i,
	input  logic sample_i,
	input  jtag_pkg::phase_err_t phase_err_i,
	output logic tdo_o,
	output jtag_pkg::acore_cfg_t acore_cfg_o,
	output jtag_pkg::cdr_cfg_t cdr_cfg_o,
	output jtag_pkg::dcore_cfg_t dcore_cfg_o
);
	import jtag_pkg::*;

	logic tdi_s;
	logic tdo_edge;
	logic tap_reset;
	logic capture_dr;
	logic shift_dr;
	logic update_dr;
	logic capture_ir;
	logic shift_ir;
	logic update_ir;
	est_t phase_est;
	est_t freq_est;

	jtag_tap_ctrl i_jtag_tap_ctrl (
		.clk          (clk),
		.reset_i      (reset_i),
		.tck_i        (tck_i),
		.tms_i        (tms_i),
		.tdi_i        (tdi_i),
		.trst_n_i     (trst_n_i),
		.tdi_s_o      (tdi_s),
		.tck_fall_o   (tdo_edge),
		.tap_reset_o  (tap_reset),
		.capture_dr_o (capture_dr),
		.shift_dr_o   (shift_dr),
		.update_dr_o  (update_dr),
		.capture_ir_o (capture_ir),
		.shift_ir_o   (shift_ir),
		.update_ir_o  (update_ir)
	);

	jtag_reg_bank #(
		.ID_CODE (ID_CODE)
	) i_jtag_reg_bank (
		.clk          (clk),
		.reset_i      (reset_i),
		.tdi_s_i      (tdi_s),
		.tck_fall_i   (tdo_edge),
		.tap_reset_i  (tap_reset),
		.capture_dr_i (capture_dr),
		.shift_dr_i   (shift_dr),
		.update_dr_i  (update_dr),
		.capture_ir_i (capture_ir),
		.shift_ir_i   (shift_ir),
		.update_ir_i  (update_ir),
		.phase_est_i  (phase_est),
		.freq_est_i   (freq_est),
		.tdo_o        (tdo_o),
		.acore_cfg_o  (acore_cfg_o),
		.cdr_cfg_o    (cdr_cfg_o),
		.dcore_cfg_o  (dcore_cfg_o)
	);

	// Loop filter held in reset by the digital core's cdr_rstb
	cdr_loop_filter i_cdr_loop_filter (
		.clk         (clk),
		.reset_i     (reset_i),
		.sample_i    (sample_i),
		.phase_err_i (phase_err_i),
		.cfg_i       (cdr_cfg_o),
		.rstb_i      (dcore_cfg_o.cdr_rstb),
		.phase_est_o (phase_est),
		.freq_est_o  (freq_est)
	);

endmodule

`default_nettype wire

// File: tests/jtag_debug_checker.sv
`timescale 1ns/10ps
`default_nettype none

module jtag_debug_checker (
	input logic clk,
	input logic reset_i,
	input logic capture_dr_i,
	input logic shift_dr_i,
	input logic update_dr_i,
	input logic capture_ir_i,
	input logic shift_ir_i,
	input logic update_ir_i,
	input jtag_pkg::jtag_instr_t ir_i,
	input jtag_pkg::acore_cfg_t acore_cfg_i,
	input jtag_pkg::cdr_cfg_t cdr_cfg_i,
	input jtag_pkg::dcore_cfg_t dcore_cfg_i
);
	import jtag_pkg::*;

	int fail_count = 0;

	// Capture, shift and update never overlap
	assert property (@(posedge clk) disable iff (reset_i)
		$onehot0({capture_dr_i, shift_dr_i, update_dr_i, capture_ir_i, shift_ir_i, update_ir_i}))
	else begin
		$error("more than one TAP control pulse in one cycle");
		fail_count++;
	end

	assert property (@(posedge clk) disable iff (reset_i)
		!$stable({acore_cfg_i, cdr_cfg_i, dcore_cfg_i}) |-> ($past(update_dr_i) || $past(reset_i)))
	else begin
		$error("configuration output changed without a preceding update_dr");
		fail_count++;
	end

	assert property (@(posedge clk) $fell(reset_i) |-> (ir_i == IR_IDCODE))
	else begin
		$error("instruction register is not IDCODE after reset");
		fail_count++;
	end

endmodule

bind jtag_reg_bank jtag_debug_checker i_jtag_debug_checker (
	.clk          (clk),
	.reset_i      (reset_i),
	.capture_dr_i (capture_dr_i),
	.shift_dr_i   (shift_dr_i),
	.update_dr_i  (update_dr_i),
	.capture_ir_i (capture_ir_i),
	.shift_ir_i   (shift_ir_i),
	.update_ir_i  (update_ir_i),
	.ir_i         (ir),
	.acore_cfg_i  (acore_cfg_o),
	.cdr_cfg_i    (cdr_cfg_o),
	.dcore_cfg_i  (dcore_cfg_o)
);

`default_nettype wire

// File: tests/jtag_debug_tb.sv
`timescale 1ns/10ps
`default_nettype none

module jtag_debug_tb;
	import jtag_pkg::*;

	localparam jtag_dr_t ID_CODE = 32'h1A5C0F01;
	localparam int WATCHDOG_CYCLES = 200000;

	logic clk;
	logic reset;
	logic tck;
	logic tms;
	logic tdi;
	logic trst_n;
	logic sample;
	phase_err_t phase_err;
	logic tdo;
	acore_cfg_t acore_cfg;
	cdr_cfg_t cdr_cfg;
	dcore_cfg_t dcore_cfg;

	// Reference model
	jtag_instr_t m_ir;
	acore_cfg_t m_acore;
	cdr_cfg_t m_cdr;
	dcore_cfg_t m_dcore;
	logic [15:0] m_phase;
	logic [15:0] m_freq;

	int errors;
	int checks;
	int tests;
	int failed_tests;
	int test_start_errors;

	jtag_debug_top #(
		.ID_CODE (ID_CODE)
	) i_jtag_debug_top (
		.clk         (clk),
		.reset_i     (reset),
		.tck_i       (tck),
		.tms_i       (tms),
		.tdi_i       (tdi),
		.trst_n_i    (trst_n),
		.sample_i    (sample),
		.phase_err_i (phase_err),
		.tdo_o       (tdo),
		.acore_cfg_o (acore_cfg),
		.cdr_cfg_o   (cdr_cfg),
		.dcore_cfg_o (dcore_cfg)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic int total_errors();
		return errors + i_jtag_debug_top.i_jtag_reg_bank.i_jtag_debug_checker.fail_count;
	endfunction

	task automatic step_clk();
		@(posedge clk);
		#1;
	endtask

	// One TCK period with TDO sampled just before the rising edge
	task automatic tck_cycle(input logic tms_v, input logic tdi_v, output logic tdo_v);
		tck = 1'b0;
		tms = tms_v;
		tdi = tdi_v;
		repeat (4) step_clk();
		tdo_v = tdo;
		tck = 1'b1;
		repeat (4) step_clk();
	endtask

	task automatic tms_seq(input logic [7:0] bits, input int n);
		logic [7:0] sh;
		logic unused;
		sh = bits;
		for (int i = 0; i < n; i++) begin
			tck_cycle(sh[0], 1'b0, unused);
			sh = sh >> 1;
		end
	endtask

	// From Run-Test-Idle back to Run-Test-Idle
	task automatic scan_ir(input jtag_instr_t code);
		jtag_instr_t sh;
		logic unused;
		sh = code;
		tms_seq(8'h03, 4);
		for (int i = 0; i < IR_WIDTH; i++) begin
			tck_cycle(i == IR_WIDTH - 1, sh[0], unused);
			sh = sh >> 1;
		end
		tms_seq(8'h01, 2);
		m_ir = code;
	endtask

	task automatic scan_dr(input int len, input logic [63:0] din, output logic [63:0] dout);
		logic [63:0] sh;
		logic [63:0] rd;
		logic b;
		sh = din;
		rd = '0;
		tms_seq(8'h01, 3);
		for (int i = 0; i < len; i++) begin
			tck_cycle(i == len - 1, sh[0], b);
			sh = sh >> 1;
			rd = {b, rd[63:1]};
		end
		tms_seq(8'h01, 2);
		dout = rd >> (64 - len);
	endtask

	task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (act !== exp) begin
			$display("** Error: %s expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_cfg();
		check_val("acore_cfg_o", 64'(m_acore), 64'(acore_cfg));
		check_val("cdr_cfg_o", 64'(m_cdr), 64'(cdr_cfg));
		check_val("dcore_cfg_o", 64'(m_dcore), 64'(dcore_cfg));
	endtask

	function automatic cfg_word_t model_word(input jtag_instr_t code);
		case (code)
			IR_CFG_ACORE: return m_acore;
			IR_CFG_CDR:   return m_cdr;
			IR_CFG_DCORE: return m_dcore;
			default:      return '0;
		endcase
	endfunction

	task automatic check_idcode();
		logic [63:0] dout;
		scan_dr(32, '0, dout);
		check_val("tdo_o", 64'(ID_CODE), dout);
	endtask

	task automatic write_cfg(input jtag_instr_t code, input cfg_word_t w);
		logic [63:0] dout;
		scan_ir(code);
		scan_dr(16, 64'(w), dout);
		// Shifted out word is the previous contents
		check_val("tdo_o", 64'(model_word(code)), dout);
		case (code)
			IR_CFG_ACORE: m_acore = acore_cfg_t'(w);
			IR_CFG_CDR:   m_cdr = cdr_cfg_t'(w);
			IR_CFG_DCORE: m_dcore = dcore_cfg_t'(w);
			default:      ;
		endcase
		check_cfg();
	endtask

	// Shifts the same word back in so the register keeps its value
	task automatic read_cfg();
		logic [63:0] dout;
		scan_dr(16, 64'(model_word(m_ir)), dout);
		check_val("tdo_o", 64'(model_word(m_ir)), dout);
	endtask

	task automatic check_bypass();
		logic [63:0] din;
		logic [63:0] dout;
		din = {24'h0, 8'($urandom), $urandom};
		scan_dr(40, din, dout);
		check_val("tdo_o", {24'h0, din[38:0], 1'b0}, dout);
	endtask

	task automatic apply_sample(input phase_err_t e);
		logic [15:0] e16;
		sample = 1'b1;
		phase_err = e;
		step_clk();
		sample = 1'b0;
		e16 = {{8{e[7]}}, e};
		if (m_cdr.en_freq_est) begin
			m_freq = m_freq + (e16 << m_cdr.Ki);
		end
		if (m_cdr.en_ext_pi_ctl) begin
			m_phase = {10'b0, m_cdr.pi_ctl_ext};
		end else begin
			m_phase = m_phase + (e16 << m_cdr.Kp) + m_freq;
		end
	endtask

	task automatic run_loop_filter(input logic ext);
		cdr_cfg_t cfg;
		dcore_cfg_t dc;
		logic [31:0] r;
		logic [63:0] dout;
		// Hold the filter in reset while the gains change
		dc = m_dcore;
		dc.cdr_rstb = 1'b0;
		write_cfg(IR_CFG_DCORE, dc);
		r = $urandom;
		cfg = cdr_cfg_t'(r[15:0]);
		cfg.Kp = {2'b00, r[17:16]};
		cfg.Ki = {2'b00, r[19:18]};
		cfg.en_freq_est = r[20];
		cfg.en_ext_pi_ctl = ext;
		write_cfg(IR_CFG_CDR, cfg);
		dc.cdr_rstb = 1'b1;
		write_cfg(IR_CFG_DCORE, dc);
		m_freq = '0;
		m_phase = ext ? {10'b0, cfg.pi_ctl_ext} : '0;
		for (int i = 0; i < 30; i++) begin
			r = $urandom;
			apply_sample(r[7:0]);
			repeat (r[9:8]) step_clk();
		end
		scan_ir(IR_STATUS_CDR);
		scan_dr(32, '0, dout);
		check_val("phase_est", 64'(m_phase), 64'(dout[31:16]));
		check_val("freq_est", 64'(m_freq), 64'(dout[15:0]));
	endtask

	task automatic end_test(input string name);
		int n;
		n = total_errors() - test_start_errors;
		tests++;
		if (n == 0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: FAILED with %0d errors", name, n);
			failed_tests++;
		end
		test_start_errors = total_errors();
	endtask

	initial begin
		int k;
		jtag_instr_t code;
		reset = 1'b1;
		tck = 1'b0;
		tms = 1'b1;
		tdi = 1'b0;
		trst_n = 1'b1;
		sample = 1'b0;
		phase_err = '0;
		m_ir = IR_IDCODE;
		m_acore = ACORE_RST;
		m_cdr = CDR_RST;
		m_dcore = DCORE_RST;
		m_phase = '0;
		m_freq = '0;
		errors = 0;
		checks = 0;
		tests = 0;
		failed_tests = 0;
		test_start_errors = 0;
		void'($urandom(47));
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		step_clk();

		check_val("tdo_o", 64'h0, 64'(tdo));
		check_cfg();
		tms_seq(8'h00, 1);
		check_idcode();
		end_test("reset");

		scan_ir(IR_BYPASS);
		check_bypass();
		// Undefined codes are 0 and 6 to 14
		k = $urandom % 10;
		code = (k == 0) ? 4'd0 : 4'(k + 5);
		scan_ir(code);
		check_bypass();
		end_test("bypass");

		for (int i = 0; i < 20; i++) begin
			k = $urandom % 3;
			code = (k == 0) ? IR_CFG_ACORE : ((k == 1) ? IR_CFG_CDR : IR_CFG_DCORE);
			write_cfg(code, 16'($urandom));
			read_cfg();
		end
		end_test("config");

		run_loop_filter(1'b0);
		run_loop_filter(1'b1);
		end_test("loop_filter");

		scan_ir(IR_CFG_ACORE);
		tms_seq(8'h1F, 5);
		m_ir = IR_IDCODE;
		tms_seq(8'h00, 1);
		check_idcode();
		check_cfg();
		scan_ir(IR_CFG_CDR);
		trst_n = 1'b0;
		repeat (4) step_clk();
		trst_n = 1'b1;
		repeat (4) step_clk();
		m_ir = IR_IDCODE;
		tms_seq(8'h00, 1);
		check_idcode();
		check_cfg();
		end_test("tap_reset");

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests, failed_tests, checks, total_errors());
		if (total_errors() == 0 && failed_tests == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
verilog/jtag_pkg.sv
verilog/jtag_tap_ctrl.sv
verilog/jtag_reg_bank.sv
verilog/cdr_loop_filter.sv
verilog/jtag_debug_top.sv
tests/jtag_debug_checker.sv
tests/jtag_debug_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --assert --timing --timescale 1ns/10ps -j 0
TOP      = jtag_debug_tb
FILELIST = compile.f
BUILD    = obj_dir
RUNFLAGS = +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP) $(RUNFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(BUILD)
